//--- hdl/rv_pkg.sv
/*
  rv_pkg: shared types and constants of the RV32I integer pipeline.
  Holds the word widths, opcodes, ALU operations, the ecall halt
  convention and the records that travel between the stages.
*/
package rv_pkg;

  typedef logic [31:0] word_t;      // operand or result
  typedef logic [31:0] pc_t;        // byte address of an instruction
  typedef logic [31:0] inst_t;      // raw instruction word
  typedef logic [4:0]  reg_addr_t;  // x0..x31

  // base opcodes kept by this core
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_system = 7'b1110011;

  // ecall halts when this register holds this value
  localparam reg_addr_t halt_reg  = 5'd17;
  localparam word_t     halt_code = 32'd10;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_pass_b  // lui
  } alu_op_e;

  // decoded instruction, ID to EX
  typedef struct packed {
    logic      valid;
    logic      reg_write;
    logic      alu_src_imm;  // second ALU input is imm
    logic      is_ecall;
    alu_op_e   alu_op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;
  } ctrl_t;

  // result record, EX/MEM and MEM/WB and the retire port
  typedef struct packed {
    logic      valid;  // rd is written
    reg_addr_t rd;
    word_t     data;
  } wb_t;

endpackage

//--- hdl/rv_decoder.sv
`timescale 1ns/10ps

/*
  rv_decoder: ID-stage decode of R-type, I-type ALU, lui and ecall.
  Produces the control record with its sign-extended immediate.
*/
module rv_decoder (
  input  rv_pkg::inst_t inst,
  input  logic          valid,
  output rv_pkg::ctrl_t ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  logic       is_ecall;
  logic       writes_rd;

  assign opcode    = inst[6:0];
  assign funct3    = inst[14:12];
  assign funct7_b5 = inst[30];
  // ebreak and csr forms differ in the upper bits
  assign is_ecall  = (opcode == rv_pkg::opc_system) && (inst[31:7] == '0);

  // funct3 to ALU op, alt selects sub and sra
  function automatic rv_pkg::alu_op_e alu_fn(input logic [2:0] f3,
                                             input logic       alt,
                                             input logic       reg_form);
    case (f3)
      3'b000:  return (alt && reg_form) ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  return rv_pkg::alu_sll;
      3'b010:  return rv_pkg::alu_slt;
      3'b011:  return rv_pkg::alu_sltu;
      3'b100:  return rv_pkg::alu_xor;
      3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  return rv_pkg::alu_or;
      default: return rv_pkg::alu_and;
    endcase
  endfunction

  always_comb begin
    writes_rd        = 1'b1;
    ctrl.alu_src_imm = 1'b1;
    ctrl.alu_op      = rv_pkg::alu_add;
    ctrl.imm         = {{20{inst[31]}}, inst[31:20]};  // I-type
    case (opcode)
      rv_pkg::opc_op: begin
        ctrl.alu_src_imm = 1'b0;
        ctrl.alu_op      = alu_fn(funct3, funct7_b5, 1'b1);
      end
      rv_pkg::opc_op_imm: begin
        ctrl.alu_op = alu_fn(funct3, funct7_b5, 1'b0);
      end
      rv_pkg::opc_lui: begin
        ctrl.alu_op = rv_pkg::alu_pass_b;
        ctrl.imm    = {inst[31:12], 12'b0};
      end
      default: begin
        writes_rd = 1'b0;  // ecall and unsupported retire as no-ops
      end
    endcase

    ctrl.valid     = valid;
    ctrl.is_ecall  = valid && is_ecall;
    ctrl.rd        = inst[11:7];
    ctrl.rs1       = is_ecall ? rv_pkg::halt_reg : inst[19:15];  // ecall reads x17
    ctrl.rs2       = inst[24:20];
    ctrl.reg_write = valid && writes_rd && (ctrl.rd != '0);
  end

endmodule

//--- hdl/rv_regfile.sv
`timescale 1ns/10ps

/*
  rv_regfile: 32 x 32 register file, x0 reads as zero.
  A read of the register written this cycle returns the new value.
*/
module rv_regfile (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  input  rv_pkg::wb_t       wr,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  rv_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.valid) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // write-before-read bypass from WB
  assign rs1_data = (rs1 == '0) ? '0 :
                    (wr.valid && wr.rd == rs1) ? wr.data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (wr.valid && wr.rd == rs2) ? wr.data : regs[rs2];

  // decoder drops rd == 0 writes long before WB
  a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
    wr.valid |-> wr.rd != '0);

endmodule

//--- hdl/rv_forward.sv
`timescale 1ns/10ps

/*
  rv_forward: EX operand selection.
  Newest result first (EX/MEM), then MEM/WB, then the ID/EX copy.
*/
module rv_forward (
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     rs2_data,
  input  rv_pkg::wb_t       ex_mem,
  input  rv_pkg::wb_t       mem_wb,
  output rv_pkg::word_t     op_a,
  output rv_pkg::word_t     op_b
);

  // one operand's mux, all inputs passed in
  function automatic rv_pkg::word_t pick(input rv_pkg::reg_addr_t idx,
                                         input rv_pkg::word_t     reg_val,
                                         input rv_pkg::wb_t       older,
                                         input rv_pkg::wb_t       oldest);
    if (idx == '0) begin
      return reg_val;  // x0 is never forwarded
    end else if (older.valid && older.rd == idx) begin
      return older.data;
    end else if (oldest.valid && oldest.rd == idx) begin
      return oldest.data;
    end
    return reg_val;
  endfunction

  assign op_a = pick(rs1, rs1_data, ex_mem, mem_wb);
  assign op_b = pick(rs2, rs2_data, ex_mem, mem_wb);

endmodule

//--- hdl/rv_alu.sv
`timescale 1ns/10ps

/*
  rv_alu: RV32I integer ALU.
  Shift amount is b[4:0]; pass_b carries the lui immediate through.
*/
module rv_alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv_pkg::alu_add:    result = a + b;
      rv_pkg::alu_sub:    result = a - b;
      rv_pkg::alu_and:    result = a & b;
      rv_pkg::alu_or:     result = a | b;
      rv_pkg::alu_xor:    result = a ^ b;
      rv_pkg::alu_sll:    result = a << shamt;
      rv_pkg::alu_srl:    result = a >> shamt;
      rv_pkg::alu_sra:    result = $signed(a) >>> shamt;
      rv_pkg::alu_slt: begin
        result = {31'b0, $signed(a) < $signed(b)};
      end
      rv_pkg::alu_sltu: begin
        result = {31'b0, a < b};
      end
      rv_pkg::alu_pass_b: result = b;
      default:            result = '0;
    endcase
  end

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/10ps

/*
  rv_core: five-stage in-order RV32I pipeline, IF ID EX MEM WB.
  Forwarding into EX, no stalls. An ecall that sees x17 == 10 in EX
  squashes the younger stages, freezes fetch and halts at WB.
*/
module rv_core #(
  parameter rv_pkg::pc_t reset_pc = '0
) (
  input  logic          clk,
  input  logic          reset,
  output rv_pkg::pc_t   imem_addr,
  input  rv_pkg::inst_t imem_data,
  output rv_pkg::wb_t   wb,
  output logic          is_halted
);

  rv_pkg::pc_t   pc;

  rv_pkg::inst_t if_id_inst;
  logic          if_id_valid;

  rv_pkg::ctrl_t id_ctrl;
  rv_pkg::word_t id_rs1_data;
  rv_pkg::word_t id_rs2_data;

  rv_pkg::ctrl_t id_ex_ctrl;
  rv_pkg::word_t id_ex_rs1_data;
  rv_pkg::word_t id_ex_rs2_data;

  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_result;
  logic          ex_halt;     // halting ecall in EX this cycle
  logic          fetch_stop;

  rv_pkg::wb_t   ex_mem;
  logic          ex_mem_halt; // sticky, doubles as the fetch freeze
  rv_pkg::wb_t   mem_wb;
  logic          mem_wb_halt;

  assign fetch_stop = ex_halt || ex_mem_halt;
  assign imem_addr  = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (!fetch_stop) begin
      pc <= pc + 32'd4;
    end
  end

  // IF/ID
  always_ff @(posedge clk) begin
    if (reset) begin
      if_id_valid <= 1'b0;
    end else begin
      if_id_valid <= !fetch_stop;  // squash what is fetched behind the halt
    end
  end

  always_ff @(posedge clk) begin
    if_id_inst <= imem_data;
  end

  rv_decoder i_decoder (
    .inst  (if_id_inst),
    .valid (if_id_valid),
    .ctrl  (id_ctrl)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (id_ctrl.rs1),
    .rs2      (id_ctrl.rs2),
    .wr       (mem_wb),
    .rs1_data (id_rs1_data),
    .rs2_data (id_rs2_data)
  );

  // ID/EX
  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex_ctrl <= '0;
    end else begin
      id_ex_ctrl       <= id_ctrl;
      id_ex_ctrl.valid <= id_ctrl.valid && !ex_halt;
    end
  end

  always_ff @(posedge clk) begin
    id_ex_rs1_data <= id_rs1_data;
    id_ex_rs2_data <= id_rs2_data;
  end

  rv_forward i_forward (
    .rs1      (id_ex_ctrl.rs1),
    .rs2      (id_ex_ctrl.rs2),
    .rs1_data (id_ex_rs1_data),
    .rs2_data (id_ex_rs2_data),
    .ex_mem   (ex_mem),
    .mem_wb   (mem_wb),
    .op_a     (op_a),
    .op_b     (op_b)
  );

  assign alu_b   = id_ex_ctrl.alu_src_imm ? id_ex_ctrl.imm : op_b;
  assign ex_halt = id_ex_ctrl.valid && id_ex_ctrl.is_ecall &&
                   (op_a == rv_pkg::halt_code);  // op_a is forwarded x17

  rv_alu i_alu (
    .op     (id_ex_ctrl.alu_op),
    .a      (op_a),
    .b      (alu_b),
    .result (alu_result)
  );

  // EX/MEM and MEM/WB, no memory stage work left
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem      <= '0;
      ex_mem_halt <= 1'b0;
      mem_wb      <= '0;
      mem_wb_halt <= 1'b0;
    end else begin
      ex_mem.valid <= id_ex_ctrl.valid && id_ex_ctrl.reg_write;
      ex_mem.rd    <= id_ex_ctrl.rd;
      ex_mem.data  <= alu_result;
      ex_mem_halt  <= ex_mem_halt || ex_halt;
      mem_wb       <= ex_mem;
      mem_wb_halt  <= mem_wb_halt || ex_mem_halt;
    end
  end

  assign wb        = mem_wb;
  assign is_halted = mem_wb_halt;

  a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
    is_halted |=> is_halted);

  a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
    wb.valid |-> wb.rd != '0);

endmodule

//--- testbench/tb_rv_core.sv
`timescale 1ns/10ps

/*
  tb_rv_core: random RV32I ALU programs run on the pipeline and on an
  in-order reference model, with retire, fetch and halt checks.
*/
module tb_rv_core;

  localparam int clk_period   = 100;
  localparam int reset_cycles = 4;
  localparam int prog_len     = 200;
  localparam int short_len    = 100;
  localparam int prefix_len   = 8;    // x17 setup and x1..x7 seeds
  localparam int tail_cycles  = 6;    // watched after the halt
  localparam int mem_words    = 512;
  localparam int watchdog_cycles = (prog_len + 20) + (short_len + 20) +
                                   2 * (prefix_len + 8 + reset_cycles);
  localparam rv_pkg::inst_t ecall_word = {25'b0, rv_pkg::opc_system};

  logic          clk;
  logic          reset;
  rv_pkg::pc_t   imem_addr;
  rv_pkg::inst_t imem_data;
  rv_pkg::wb_t   wb;
  logic          is_halted;

  rv_pkg::inst_t prog [mem_words];
  rv_pkg::wb_t   expected [$];  // model retire order
  int            dep_seen [1:3];  // operand reads at distance 1..3
  int            value_errors;
  int            other_errors;

  rv_core #(.reset_pc(32'd0)) i_dut (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .wb        (wb),
    .is_halted (is_halted)
  );

  assign imem_data = prog[imem_addr[10:2]];  // combinational read port

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic rv_pkg::inst_t r_type(input logic [6:0] f7, input rv_pkg::reg_addr_t rs2,
                                           input rv_pkg::reg_addr_t rs1, input logic [2:0] f3,
                                           input rv_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::opc_op};
  endfunction

  function automatic rv_pkg::inst_t i_type(input logic [11:0] imm, input rv_pkg::reg_addr_t rs1,
                                           input logic [2:0] f3, input rv_pkg::reg_addr_t rd);
    return {imm, rs1, f3, rd, rv_pkg::opc_op_imm};
  endfunction

  function automatic rv_pkg::inst_t u_type(input logic [19:0] imm, input rv_pkg::reg_addr_t rd);
    return {imm, rd, rv_pkg::opc_lui};
  endfunction

  // registers x0..x7 only, so dependences are dense
  function automatic rv_pkg::inst_t random_inst();
    int                kind;
    logic [2:0]        f3;
    logic              alt;
    logic [11:0]       imm;
    rv_pkg::reg_addr_t rd;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    kind = $urandom_range(0, 9);
    f3   = 3'($urandom_range(0, 7));
    alt  = 1'($urandom_range(0, 1));
    imm  = 12'($urandom);
    rd   = 5'($urandom_range(0, 7));
    rs1  = 5'($urandom_range(0, 7));
    rs2  = 5'($urandom_range(0, 7));
    if (kind < 4) begin
      return r_type((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
    end
    if (kind < 9) begin
      if (f3 == 3'd1) imm = {7'h00, imm[4:0]};  // slli
      if (f3 == 3'd5) imm = {1'b0, alt, 5'h00, imm[4:0]};  // srli or srai
      return i_type(imm, rs1, f3, rd);
    end
    return u_type(20'($urandom), rd);
  endfunction

  task automatic build_program(input int body_len, input bit mid_ecall);
    int pos;
    for (int i = 0; i < mem_words; i++) begin
      prog[i] = i_type(12'(i), 5'd5, 3'd0, 5'd5);  // filler, imm follows the address
    end
    prog[0] = i_type(12'($urandom_range(0, 9)), 5'd0, 3'd0, 5'd17);  // x17 never 10 here
    for (int r = 1; r < prefix_len; r++) begin
      prog[r] = i_type(12'($urandom), 5'd0, 3'd0, 5'(r));
    end
    pos = prefix_len;
    for (int k = 0; k < body_len; k++) begin
      if (mid_ecall && k == body_len / 2) begin
        prog[pos] = ecall_word;  // must not halt
        pos++;
      end
      prog[pos] = random_inst();
      pos++;
    end
    prog[pos]     = i_type(12'd10, 5'd0, 3'd0, 5'd17);
    prog[pos + 1] = ecall_word;
  endtask

  // in-order ISA model, fills expected and finds the halting ecall
  task automatic model_program(output int halt_idx);
    rv_pkg::word_t     regs [32];
    int                last_wr [32];
    rv_pkg::inst_t     inst;
    rv_pkg::word_t     a;
    rv_pkg::word_t     b;
    rv_pkg::word_t     res;
    logic [2:0]        f3;
    logic              is_r;
    rv_pkg::reg_addr_t rd;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    for (int r = 0; r < 32; r++) begin
      regs[r]    = '0;
      last_wr[r] = -100;
    end
    expected.delete();
    halt_idx = -1;
    for (int i = 0; i < mem_words && halt_idx < 0; i++) begin
      inst = prog[i];
      f3   = inst[14:12];
      rd   = inst[11:7];
      rs1  = inst[19:15];
      rs2  = inst[24:20];
      is_r = (inst[6:0] == rv_pkg::opc_op);
      if (inst == ecall_word) begin
        if (regs[17] == rv_pkg::halt_code) halt_idx = i;
        continue;
      end
      if (inst[6:0] == rv_pkg::opc_lui) begin
        res = {inst[31:12], 12'b0};
      end else begin
        if (rs1 != 0 && i - last_wr[rs1] <= 3) dep_seen[i - last_wr[rs1]]++;
        if (is_r && rs2 != 0 && i - last_wr[rs2] <= 3) dep_seen[i - last_wr[rs2]]++;
        a = regs[rs1];
        b = is_r ? regs[rs2] : {{20{inst[31]}}, inst[31:20]};
        case (f3)
          3'd0: res = (is_r && inst[30]) ? a - b : a + b;
          3'd1: res = a << b[4:0];
          3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'd3: res = (a < b) ? 32'd1 : 32'd0;
          3'd4: res = a ^ b;
          3'd5: begin
            if (inst[30]) begin
              res = $signed(a) >>> b[4:0];  // sign fills from the left
            end else begin
              res = a >> b[4:0];
            end
          end
          3'd6: res = a | b;
          default: res = a & b;
        endcase
      end
      if (rd != 0) begin  // x0 writes never retire
        regs[rd]    = res;
        last_wr[rd] = i;
        expected.push_back({1'b1, rd, res});
      end
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      value_errors++;
      $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_record();
    rv_pkg::wb_t rec;
    assert (expected.size() > 0) else begin
      other_errors++;
      $display("at %0t: x%0d retired after the last expected record", $time, wb.rd);
    end
    if (expected.size() > 0) begin
      rec = expected.pop_front();
      check_word("wb.rd", 32'(rec.rd), 32'(wb.rd));
      check_word("wb.data", rec.data, wb.data);
    end
  endtask

  // one reset, one program, run until the halt plus a short tail
  task automatic run_program(input int body_len, input bit mid_ecall);
    int halt_idx;
    int cycle;
    int rise;
    build_program(body_len, mid_ecall);
    model_program(halt_idx);
    @(negedge clk);
    reset = 1'b1;
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
    cycle = 0;
    rise  = -1;
    check_word("wb.valid", 32'd0, 32'(wb.valid));
    while (rise < 0 || cycle < rise + tail_cycles) begin
      // fetch freezes once the ecall is in EX
      check_word("imem_addr", 32'(4 * ((cycle < halt_idx + 2) ? cycle : halt_idx + 2)),
                 imem_addr);
      check_word("is_halted", 32'(cycle >= halt_idx + 4), 32'(is_halted));
      if (is_halted && rise < 0) rise = cycle;
      if (wb.valid) check_record();
      @(negedge clk);
      cycle++;
    end
    assert (expected.size() == 0) else begin
      other_errors++;
      $display("%0d expected records never retired", expected.size());
    end
  endtask

  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: the core did not finish within %0d cycles", watchdog_cycles);
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    $display("Errors found");
    $finish;
  end

  initial begin
    reset        = 1'b1;
    value_errors = 0;
    other_errors = 0;
    dep_seen     = '{0, 0, 0};
    void'($urandom(32'h07f2ee60));
    run_program(prog_len, 1'b0);
    run_program(short_len, 1'b1);  // non-halting ecall in the middle
    for (int d = 1; d <= 3; d++) begin
      assert (dep_seen[d] > 0) else begin
        other_errors++;
        $display("no operand was read at distance %0d from its producer", d);
      end
    end
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- sources.f
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_forward.sv
hdl/rv_alu.sv
hdl/rv_core.sv
testbench/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/rv_decoder.sv
  - hdl/rv_regfile.sv
  - hdl/rv_forward.sv
  - hdl/rv_alu.sv
  - hdl/rv_core.sv
  - target: simulation
    files:
      - testbench/tb_rv_core.sv
